// ==== verilog/epd_pkg.sv ====
package epd_pkg;

    ////////////////////
    // Widths

    localparam int pix_per_word = 8;
    localparam int gray_bits    = 4;
    localparam int drive_bits   = 2;

    // Drive codes on the source bus
    localparam logic [drive_bits-1:0] drive_none    = 2'b00;
    localparam logic [drive_bits-1:0] drive_darken  = 2'b01;
    localparam logic [drive_bits-1:0] drive_lighten = 2'b10;

    // Counter width for n states, never below one bit
    function automatic int cnt_width(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    ////////////////////
    // Pixel word

    // Direct field, host-computed code in the low bits
    typedef struct packed {
        logic [gray_bits-drive_bits-1:0] rsvd;
        logic [drive_bits-1:0]           code;
    } direct_pix_t;

    // Pixel 0 sits in the least significant field in both views
    typedef union packed {
        logic [pix_per_word-1:0][gray_bits-1:0] gray;
        direct_pix_t [pix_per_word-1:0]         direct;
    } pix_word_t;

    ////////////////////
    // Driver timing

    typedef struct packed {
        logic sdclk;
        logic sdle;
        logic sdoe;
        logic gdclk;
        logic gdsp;
        logic gdoe;
        // Pixel word valid on the bus this cycle
        logic active;
    } epd_timing_t;

endpackage

// ==== verilog/power_seq.sv ====
module power_seq import epd_pkg::*; #(
    parameter int step_cycles = 1000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       power_en,
    output logic [2:0] rail_en,
    output logic       pok
);

    localparam int cnt_w = cnt_width(step_cycles);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(step_cycles - 1);

    // Number of rails switched on, 0 to 3
    logic [1:0]       level;
    logic [cnt_w-1:0] step_cnt;
    logic             moving;

    // Rails left to switch in the direction set by power_en
    assign moving = power_en ? (level != 2'd3) : (level != 2'd0);

    ////////////////////
    // Step sequencer

    always_ff @(posedge clk) begin
        if (rst) begin
            level    <= 2'd0;
            step_cnt <= '0;
            pok      <= 1'b0;
        end else begin
            if (!moving) begin
                step_cnt <= '0;
            end else if (step_cnt == cnt_last) begin
                step_cnt <= '0;
                if (power_en) begin
                    level <= level + 2'd1;
                end else begin
                    level <= level - 2'd1;
                end
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
            // Drops one cycle after power_en goes low
            pok <= power_en && (level == 2'd3);
        end
    end

    // Rails on in order 0, 1, 2 and off in reverse
    assign rail_en = {level == 2'd3, level >= 2'd2, level != 2'd0};

    ////////////////////
    // Checks

    pok_rails_on: assert property (
        @(posedge clk) disable iff (rst) pok |-> &rail_en
    ) else $error("pok high with a rail still off");

endmodule

// ==== verilog/scan_timing.sv ====
module scan_timing import epd_pkg::*; #(
    parameter int h_words = 200,
    parameter int v_lines = 1200,
    parameter int frames  = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic                         pok,
    output epd_timing_t                  timing,
    output logic [cnt_width(frames)-1:0] frame,
    output logic                         pix_req,
    output logic                         busy,
    output logic                         done
);

    localparam int word_w  = cnt_width(h_words + 2);
    localparam int line_w  = cnt_width(v_lines);
    localparam int frame_w = cnt_width(frames);

    // Word slot h_words holds latch and gate clock, the next one is idle
    localparam logic [word_w-1:0]  word_latch = word_w'(h_words);
    localparam logic [word_w-1:0]  word_last  = word_w'(h_words + 1);
    localparam logic [line_w-1:0]  line_last  = line_w'(v_lines - 1);
    localparam logic [frame_w-1:0] frame_last = frame_w'(frames - 1);

    logic [word_w-1:0] word;
    logic              phase;
    logic [line_w-1:0] line;
    logic              in_data;

    assign in_data = (word < word_latch);

    ////////////////////
    // Counters

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            word  <= '0;
            phase <= 1'b0;
            line  <= '0;
            frame <= '0;
        end else begin
            done <= 1'b0;
            if (!busy || !pok) begin
                // Idle, or abort on power loss without done
                word  <= '0;
                phase <= 1'b0;
                line  <= '0;
                frame <= '0;
                busy  <= !busy && pok && start;
            end else begin
                phase <= ~phase;
                if (phase) begin
                    if (word == word_last) begin
                        word <= '0;
                        if (line == line_last) begin
                            line <= '0;
                            if (frame == frame_last) begin
                                frame <= '0;
                                busy  <= 1'b0;
                                done  <= 1'b1;
                            end else begin
                                frame <= frame + 1'b1;
                            end
                        end else begin
                            line <= line + 1'b1;
                        end
                    end else begin
                        word <= word + 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////
    // Driver timing decode

    // Request while sdclk is low, data expected while it is high
    assign pix_req       = busy && in_data && !phase;
    assign timing.sdclk  = busy && in_data && phase;
    assign timing.active = busy && in_data && phase;
    assign timing.sdle   = busy && (word == word_latch) && !phase;
    assign timing.gdclk  = busy && (word == word_latch) && phase;
    assign timing.gdsp   = busy && (line == '0);
    assign timing.sdoe   = busy;
    assign timing.gdoe   = busy;

    ////////////////////
    // Checks

    latch_vs_clock: assert property (
        @(posedge clk) disable iff (rst) !(timing.sdle && timing.sdclk)
    ) else $error("sdle and sdclk high together");

endmodule

// ==== verilog/epd_output.sv ====
module epd_output import epd_pkg::*; #(
    parameter int frames = 16
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  epd_timing_t                          timing,
    input  logic [cnt_width(frames)-1:0]         frame,
    input  logic                                 busy,
    input  logic                                 pok,
    input  logic                                 mode_direct,
    input  pix_word_t                            pix_word,
    output logic [pix_per_word*drive_bits-1:0]   epd_sd,
    output logic                                 epd_sdclk,
    output logic                                 epd_sdle,
    output logic                                 epd_sdoe,
    output logic                                 epd_sdce0,
    output logic                                 epd_gdclk,
    output logic                                 epd_gdsp,
    output logic                                 epd_gdoe,
    output logic                                 error
);

    // Code i lands on epd_sd bits 2i+1 down to 2i
    logic [pix_per_word-1:0][drive_bits-1:0] codes;
    logic                                    pok_q;

    ////////////////////
    // Pixel decode

    always_comb begin
        for (int i = 0; i < pix_per_word; i++) begin
            if (mode_direct) begin
                codes[i] = pix_word.direct[i].code;
            end else if (32'(frame) < 32'(pix_word.gray[i])) begin
                // Lighter levels keep getting pulses for more frames
                codes[i] = drive_lighten;
            end else begin
                codes[i] = drive_none;
            end
        end
    end

    ////////////////////
    // Pin registers

    always_ff @(posedge clk) begin
        if (rst) begin
            pok_q     <= 1'b0;
            epd_sd    <= '0;
            epd_sdclk <= 1'b0;
            epd_sdle  <= 1'b0;
            epd_sdoe  <= 1'b0;
            epd_sdce0 <= 1'b0;
            epd_gdclk <= 1'b0;
            epd_gdsp  <= 1'b0;
            epd_gdoe  <= 1'b0;
            error     <= 1'b0;
        end else begin
            pok_q     <= pok;
            epd_sdclk <= pok && timing.sdclk;
            epd_sdle  <= pok && timing.sdle;
            epd_sdoe  <= pok && timing.sdoe;
            epd_gdclk <= pok && timing.gdclk;
            epd_gdsp  <= pok && timing.gdsp;
            epd_gdoe  <= pok && timing.gdoe;
            // Chip enable is active low, deselected when idle
            epd_sdce0 <= pok && !busy;
            if (!pok) begin
                epd_sd <= '0;
            end else if (timing.active) begin
                epd_sd <= codes;
            end
            // Sticky until reset
            if (busy && !pok) begin
                error <= 1'b1;
            end
        end
    end

    ////////////////////
    // Checks

    pins_off_without_power: assert property (
        @(posedge clk) disable iff (rst) !pok_q |->
            (epd_sd == '0) && !epd_sdclk && !epd_sdle && !epd_sdoe && !epd_sdce0
            && !epd_gdclk && !epd_gdsp && !epd_gdoe
    ) else $error("panel pin driven without power good");

endmodule

// ==== verilog/epd_ctrl.sv ====
module epd_ctrl import epd_pkg::*; #(
    parameter int h_words     = 200,
    parameter int v_lines     = 1200,
    parameter int frames      = 16,
    parameter int step_cycles = 1000
) (
    input  logic                               clk,
    input  logic                               rst,
    // Host side
    input  logic                               power_en,
    input  logic                               start,
    input  logic                               mode_direct,
    input  pix_word_t                          pix_word,
    output logic                               pix_req,
    output logic                               busy,
    output logic                               done,
    output logic                               pok,
    output logic                               error,
    // Panel side
    output logic [2:0]                         rail_en,
    output logic [pix_per_word*drive_bits-1:0] epd_sd,
    output logic                               epd_sdclk,
    output logic                               epd_sdle,
    output logic                               epd_sdoe,
    output logic                               epd_sdce0,
    output logic                               epd_gdclk,
    output logic                               epd_gdsp,
    output logic                               epd_gdoe
);

    epd_timing_t                  timing;
    logic [cnt_width(frames)-1:0] frame;

    power_seq #(
        .step_cycles(step_cycles)
    ) i_power_seq (
        .clk(clk),
        .rst(rst),
        .power_en(power_en),
        .rail_en(rail_en),
        .pok(pok)
    );

    scan_timing #(
        .h_words(h_words),
        .v_lines(v_lines),
        .frames(frames)
    ) i_scan_timing (
        .clk(clk),
        .rst(rst),
        .start(start),
        .pok(pok),
        .timing(timing),
        .frame(frame),
        .pix_req(pix_req),
        .busy(busy),
        .done(done)
    );

    // Pins lag timing by one cycle
    epd_output #(
        .frames(frames)
    ) i_epd_output (
        .clk(clk),
        .rst(rst),
        .timing(timing),
        .frame(frame),
        .busy(busy),
        .pok(pok),
        .mode_direct(mode_direct),
        .pix_word(pix_word),
        .epd_sd(epd_sd),
        .epd_sdclk(epd_sdclk),
        .epd_sdle(epd_sdle),
        .epd_sdoe(epd_sdoe),
        .epd_sdce0(epd_sdce0),
        .epd_gdclk(epd_gdclk),
        .epd_gdsp(epd_gdsp),
        .epd_gdoe(epd_gdoe),
        .error(error)
    );

endmodule

// ==== tb/tb_epd_ctrl.sv ====
module tb_epd_ctrl import epd_pkg::*; ();

    localparam int h_words     = 4;
    localparam int v_lines     = 3;
    localparam int frames      = 4;
    localparam int step_cycles = 5;
    localparam int n_rows      = 5;
    localparam int line_len    = 2 * h_words + 4;
    localparam int update_len  = frames * v_lines * line_len;
    // Each row may need a full update, a power cycle and some slack
    localparam int cycle_limit = n_rows * (update_len + 8 * step_cycles + 50) + 500;

    typedef struct packed {
        logic mode_direct;
        logic random_pat;
        logic drop_power;
        logic exp_error;
    } row_t;

    logic        clk;
    logic        rst;
    logic        power_en;
    logic        start;
    logic        mode_direct;
    logic [31:0] pix_word = '0;
    logic        pix_req;
    logic        busy;
    logic        done;
    logic        pok;
    logic        error;
    logic [2:0]  rail_en;
    logic [15:0] epd_sd;
    logic        epd_sdclk;
    logic        epd_sdle;
    logic        epd_sdoe;
    logic        epd_sdce0;
    logic        epd_gdclk;
    logic        epd_gdsp;
    logic        epd_gdoe;

    row_t        rows [n_rows];
    row_t        cur_row = '0;
    logic [31:0] sent [$];
    int          cycle = 0;
    int          checks = 0;
    int          errors = 0;
    int          word_no = 0;
    int          frame_idx = -1;
    int          line_sdclk = 0;
    int          frame_gdclk = 0;
    int          sdclk_cnt = 0;
    int          gdclk_cnt = 0;
    int          gdsp_cnt = 0;
    int          sdle_cnt = 0;
    int          done_cnt = 0;
    logic        sdclk_q = 1'b0;
    logic        gdclk_q = 1'b0;
    logic        gdsp_q = 1'b0;

    epd_ctrl #(
        .h_words(h_words),
        .v_lines(v_lines),
        .frames(frames),
        .step_cycles(step_cycles)
    ) i_epd_ctrl (
        .clk(clk),
        .rst(rst),
        .power_en(power_en),
        .start(start),
        .mode_direct(mode_direct),
        .pix_word(pix_word),
        .pix_req(pix_req),
        .busy(busy),
        .done(done),
        .pok(pok),
        .error(error),
        .rail_en(rail_en),
        .epd_sd(epd_sd),
        .epd_sdclk(epd_sdclk),
        .epd_sdle(epd_sdle),
        .epd_sdoe(epd_sdoe),
        .epd_sdce0(epd_sdce0),
        .epd_gdclk(epd_gdclk),
        .epd_gdsp(epd_gdsp),
        .epd_gdoe(epd_gdoe)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // Helpers

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    // Levels spread over 0 to 15 so every frame sees some transitions
    function automatic logic [31:0] fixed_word(input int k);
        return 32'h01234567 + 32'(k) * 32'h11111111;
    endfunction

    // Lighten while the frame number is below the level, direct codes pass through
    function automatic logic [15:0] expected_sd(input logic [31:0] word, input logic direct,
                                                input int frame_no);
        logic [15:0] sd;
        logic [3:0]  field;
        sd = '0;
        for (int i = 0; i < 8; i++) begin
            field = word[4*i +: 4];
            if (direct) begin
                sd[2*i +: 2] = field[1:0];
            end else if (frame_no < int'(field)) begin
                sd[2*i +: 2] = drive_lighten;
            end else begin
                sd[2*i +: 2] = drive_none;
            end
        end
        return sd;
    endfunction

    function automatic logic [31:0] panel_pins();
        return 32'({epd_sd, epd_sdclk, epd_sdle, epd_sdoe, epd_sdce0,
                    epd_gdclk, epd_gdsp, epd_gdoe});
    endfunction

    ////////////////////
    // Host model and pin monitor

    always @(negedge clk) begin
        logic [31:0] word;
        logic [15:0] exp_sd;
        if (pix_req) begin
            word = cur_row.random_pat ? $urandom : fixed_word(word_no);
            word_no++;
            pix_word = word;
            sent.push_back(word);
        end
        if (epd_gdsp && !gdsp_q) begin
            if (frame_idx >= 0) begin
                compare_value("gdclk per frame", frame_gdclk, v_lines);
            end
            frame_idx++;
            frame_gdclk = 0;
            gdsp_cnt++;
        end
        if (epd_gdclk && !gdclk_q) begin
            compare_value("sdclk per line", line_sdclk, h_words);
            line_sdclk = 0;
            frame_gdclk++;
            gdclk_cnt++;
        end
        if (epd_sdclk && !sdclk_q) begin
            if (sent.size() == 0) begin
                errors++;
                $display("epd_sdclk rose with no pixel word outstanding");
            end else begin
                exp_sd = expected_sd(sent.pop_front(), mode_direct, frame_idx);
                compare_value("epd_sd", 32'(epd_sd), 32'(exp_sd));
            end
            // Drivers enabled and source chip selected while data shifts
            compare_value("epd_sdoe", 32'(epd_sdoe), 32'h1);
            compare_value("epd_gdoe", 32'(epd_gdoe), 32'h1);
            compare_value("epd_sdce0", 32'(epd_sdce0), 32'h0);
            line_sdclk++;
            sdclk_cnt++;
        end
        if (epd_sdle) begin
            sdle_cnt++;
        end
        if (done) begin
            done_cnt++;
        end
        sdclk_q = epd_sdclk;
        gdclk_q = epd_gdclk;
        gdsp_q  = epd_gdsp;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle > cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT never finished", cycle);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////
    // Sequences

    task automatic power_up();
        int         t_drive;
        int         t_last;
        logic [2:0] rail_q;
        power_en = 1'b1;
        t_drive  = cycle;
        t_last   = -1;
        rail_q   = rail_en;
        while (!pok) begin
            @(negedge clk);
            if (rail_en != rail_q) begin
                // Rails come on one at a time, lowest first
                compare_value("rail_en", 32'(rail_en), 32'({rail_q[1:0], 1'b1}));
                if (t_last >= 0) begin
                    compare_value("rail step cycles", cycle - t_last, step_cycles);
                end
                t_last = cycle;
                rail_q = rail_en;
            end
        end
        compare_value("pok delay", cycle - t_drive - 1, 3 * step_cycles);
        compare_value("rail_en", 32'(rail_en), 32'h7);
    endtask

    task automatic run_row(input int r);
        int errors_before;
        int t_start;
        errors_before = errors;
        cur_row     = rows[r];
        mode_direct = cur_row.mode_direct;
        sent.delete();
        word_no     = 0;
        frame_idx   = -1;
        line_sdclk  = 0;
        frame_gdclk = 0;
        sdclk_cnt   = 0;
        gdclk_cnt   = 0;
        gdsp_cnt    = 0;
        sdle_cnt    = 0;
        done_cnt    = 0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!busy) @(negedge clk);
        t_start = cycle;
        if (cur_row.drop_power) begin
            // Cut power in the middle of the second frame
            while (gdsp_cnt < 2) @(negedge clk);
            repeat (5) @(negedge clk);
            power_en = 1'b0;
            @(negedge clk);
            compare_value("pok", 32'(pok), 32'h0);
            @(negedge clk);
            compare_value("busy", 32'(busy), 32'h0);
            compare_value("error", 32'(error), 32'(cur_row.exp_error));
            compare_value("panel pins", panel_pins(), 32'h0);
            repeat (line_len) @(negedge clk);
            compare_value("done count", done_cnt, 0);
            compare_value("error", 32'(error), 32'(cur_row.exp_error));
            compare_value("panel pins", panel_pins(), 32'h0);
            rst = 1'b1;
            repeat (2) @(negedge clk);
            rst = 1'b0;
            compare_value("error after reset", 32'(error), 32'h0);
            power_up();
        end else begin
            while (!done) @(negedge clk);
            compare_value("update cycles", cycle - t_start, update_len);
            repeat (3) @(negedge clk);
            compare_value("done count", done_cnt, 1);
            compare_value("busy", 32'(busy), 32'h0);
            compare_value("sdclk count", sdclk_cnt, frames * v_lines * h_words);
            compare_value("gdclk count", gdclk_cnt, frames * v_lines);
            compare_value("sdle count", sdle_cnt, frames * v_lines);
            compare_value("gdsp count", gdsp_cnt, frames);
            compare_value("gdclk per frame", frame_gdclk, v_lines);
            compare_value("words left", sent.size(), 0);
            compare_value("error", 32'(error), 32'(cur_row.exp_error));
            // Idle with power good, drivers off and chip deselected
            compare_value("epd_sdoe idle", 32'(epd_sdoe), 32'h0);
            compare_value("epd_gdoe idle", 32'(epd_gdoe), 32'h0);
            compare_value("epd_sdce0 idle", 32'(epd_sdce0), 32'h1);
        end
        $display("row %0d %s %s%s: %0d errors", r, cur_row.mode_direct ? "direct" : "gray",
                 cur_row.random_pat ? "random" : "fixed",
                 cur_row.drop_power ? " power loss" : "", errors - errors_before);
    endtask

    ////////////////////
    // Main

    initial begin
        logic [31:0] seed_ret;
        seed_ret = $urandom(32'h4930);
        // mode_direct, random_pat, drop_power, exp_error
        rows[0] = '{1'b0, 1'b0, 1'b0, 1'b0};
        rows[1] = '{1'b0, 1'b1, 1'b0, 1'b0};
        rows[2] = '{1'b1, 1'b0, 1'b0, 1'b0};
        rows[3] = '{1'b1, 1'b1, 1'b0, 1'b0};
        rows[4] = '{1'b0, 1'b1, 1'b1, 1'b1};
        rst         = 1'b1;
        power_en    = 1'b0;
        start       = 1'b0;
        mode_direct = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        // Start without power good must be ignored
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (3) begin
            compare_value("busy", 32'(busy), 32'h0);
            @(negedge clk);
        end
        compare_value("busy", 32'(busy), 32'h0);
        power_up();
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("rows %0d, checks %0d, errors %0d, seed %h", n_rows, checks, errors,
                 seed_ret);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/epd_pkg.sv
verilog/power_seq.sv
verilog/scan_timing.sv
verilog/epd_output.sv
verilog/epd_ctrl.sv
tb/tb_epd_ctrl.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = tb_epd_ctrl
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
